// File: cpu16.f
+incdir+design
design/cpu16_pkg.sv
design/instr_decoder.sv
design/alu.sv
design/register_file.sv
design/cycle_control.sv
design/cpu16_top.sv
verification/cpu16_asserts.sv
verification/cpu16_tb.sv

// File: design/alu.sv
// alu: register results of 1- and 2-register operations and the compare flag word
`include "cpu16_macros.svh"

module alu (
  input  cpu16_pkg::op_t              op,
  input  logic [`CPU16_WORD_BITS-1:0] reg_a,
  input  logic [`CPU16_WORD_BITS-1:0] reg_b,
  input  logic [`CPU16_WORD_BITS-1:0] status_in,
  output logic [`CPU16_WORD_BITS-1:0] alu_result,
  output logic                        alu_writes,
  output logic                        flags_write
);

  localparam int W = `CPU16_WORD_BITS;

  logic [5:0] cmp_flags;  // unsigned relations of a and b

  always_comb begin
    cmp_flags = '0;
    cmp_flags[cpu16_pkg::FLAG_EQ] = reg_a == reg_b;
    cmp_flags[cpu16_pkg::FLAG_NE] = reg_a != reg_b;
    cmp_flags[cpu16_pkg::FLAG_GT] = reg_a > reg_b;
    cmp_flags[cpu16_pkg::FLAG_GE] = reg_a >= reg_b;
    cmp_flags[cpu16_pkg::FLAG_LT] = reg_a < reg_b;
    cmp_flags[cpu16_pkg::FLAG_LE] = reg_a <= reg_b;
  end

  // --------------------------------------------------
  // result select
  // --------------------------------------------------
  always_comb begin
    alu_result  = reg_a;
    alu_writes  = 1'b1;
    flags_write = 1'b0;
    case (op)
      cpu16_pkg::OP_MOV:  alu_result = reg_a;  // lands in b
      cpu16_pkg::OP_ADD:  alu_result = reg_a + reg_b;
      cpu16_pkg::OP_SUB:  alu_result = reg_a - reg_b;
      cpu16_pkg::OP_SHL:  alu_result = reg_a << reg_b;  // >= 16 clears
      cpu16_pkg::OP_SHR:  alu_result = reg_a >> reg_b;
      cpu16_pkg::OP_AND:  alu_result = reg_a & reg_b;
      cpu16_pkg::OP_OR:   alu_result = reg_a | reg_b;
      cpu16_pkg::OP_NOT:  alu_result = ~reg_a;
      cpu16_pkg::OP_LNOT: alu_result = {{(W-1){1'b0}}, reg_a == '0};
      cpu16_pkg::OP_SHL1: alu_result = {reg_a[W-2:0], 1'b0};
      cpu16_pkg::OP_SHR1: alu_result = {1'b0, reg_a[W-1:1]};
      cpu16_pkg::OP_ROL1: alu_result = {reg_a[W-2:0], reg_a[W-1]};
      cpu16_pkg::OP_ROR1: alu_result = {reg_a[0], reg_a[W-1:1]};
      cpu16_pkg::OP_CMP: begin
        alu_result  = {status_in[W-1:6], cmp_flags};  // upper status bits kept
        alu_writes  = 1'b0;
        flags_write = 1'b1;
      end
      default: alu_writes = 1'b0;  // jumps, selects, memory, control
    endcase
  end

endmodule

// File: design/cpu16_macros.svh
// cpu16 macros: word and address widths, special register indices, entry point
`ifndef CPU16_MACROS_SVH
`define CPU16_MACROS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define CPU16_WORD_BITS 16   // data word
`define CPU16_ADDR_BITS 16   // memory address
`define CPU16_NUM_REGS 16    // general registers
`define CPU16_REG_BITS 4     // register index

// --------------------------------------------------
// special registers and encoding
// --------------------------------------------------
`define CPU16_IP_IDX 4'd12       // program counter lives here
`define CPU16_STATUS_IDX 4'd15   // compare flags and condition bit
`define CPU16_ENTRY_ADDR 16'h0000  // pc after reset
`define CPU16_IMM_BIT 13         // set when an immediate word follows

`endif

// File: design/cpu16_pkg.sv
// cpu16 package: sequencer states, instruction families, operations, flag positions
package cpu16_pkg;

  // sequencer state
  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    LOAD_IMM,    // second word of an immediate form
    EXEC,
    MEM_ACCESS,  // data load or store
    HALTED
  } cycle_t;

  // instruction family, from top bits and immediate flag
  typedef enum logic [1:0] {
    CLASS_ZERO,
    CLASS_ONE_IMM,
    CLASS_ONE,
    CLASS_TWO
  } instr_class_t;

  // --------------------------------------------------
  // operations
  // --------------------------------------------------
  typedef enum logic [4:0] {
    OP_MOV,        // a -> b
    OP_ADD,
    OP_SUB,
    OP_SHL,        // shift by register
    OP_SHR,
    OP_CMP,        // flags -> status
    OP_AND,
    OP_OR,
    OP_LOAD_IMM,
    OP_LOAD_MEM,
    OP_STORE,
    OP_JUMP_COND,
    OP_JUMP_ABS,
    OP_JUMP_REL,
    OP_NOT,        // bitwise
    OP_LNOT,       // logical
    OP_SHL1,
    OP_SHR1,
    OP_ROL1,
    OP_ROR1,
    OP_SEL_EQ,     // condition selects
    OP_SEL_NE,
    OP_SEL_GT,
    OP_SEL_GE,
    OP_SEL_LT,
    OP_SEL_LE,
    OP_NOP,
    OP_HALT,
    OP_ILLEGAL
  } op_t;

  // compare flag bits in the status register
  localparam logic [2:0] FLAG_EQ = 3'd0;
  localparam logic [2:0] FLAG_NE = 3'd1;
  localparam logic [2:0] FLAG_GT = 3'd2;
  localparam logic [2:0] FLAG_GE = 3'd3;
  localparam logic [2:0] FLAG_LT = 3'd4;
  localparam logic [2:0] FLAG_LE = 3'd5;

endpackage

// File: design/cpu16_top.sv
// cpu16 top level joining decoder, alu, register file and sequencer to the memory port
`include "cpu16_macros.svh"

module cpu16_top (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        mem_ack,
  input  logic [`CPU16_WORD_BITS-1:0] mem_rdata,
  output logic                        mem_req,
  output logic                        mem_write,
  output logic [`CPU16_ADDR_BITS-1:0] mem_addr,
  output logic [`CPU16_WORD_BITS-1:0] mem_wdata,
  output logic [`CPU16_WORD_BITS-1:0] instr,   // current instruction for debug
  output logic [`CPU16_ADDR_BITS-1:0] pc,      // program counter for debug
  output logic                        halted
);

  cpu16_pkg::instr_class_t     instr_class;
  cpu16_pkg::op_t              op;
  logic [`CPU16_REG_BITS-1:0]  idx_a;
  logic [`CPU16_REG_BITS-1:0]  idx_b;
  logic [`CPU16_WORD_BITS-1:0] reg_a;
  logic [`CPU16_WORD_BITS-1:0] reg_b;
  logic                        cond_flag;
  logic [`CPU16_WORD_BITS-1:0] alu_result;
  logic                        alu_writes;
  logic                        flags_write;
  logic                        wr_en;
  logic [`CPU16_REG_BITS-1:0]  wr_idx;
  logic [`CPU16_WORD_BITS-1:0] wr_data;
  logic                        pc_inc;
  logic                        pc_load;
  logic [`CPU16_ADDR_BITS-1:0] pc_value;
  logic                        status_sel_en;
  logic [2:0]                  status_sel_bit;

  instr_decoder i_instr_decoder (
    .instr(instr), .instr_class(instr_class), .op(op), .idx_a(idx_a), .idx_b(idx_b)
  );

  // compare keeps the upper status bits, read straight from register 15
  alu i_alu (
    .op(op), .reg_a(reg_a), .reg_b(reg_b),
    .status_in(i_register_file.regs[`CPU16_STATUS_IDX]),
    .alu_result(alu_result), .alu_writes(alu_writes), .flags_write(flags_write)
  );

  register_file i_register_file (
    .in_clk(in_clk), .in_rst(in_rst), .idx_a(idx_a), .idx_b(idx_b),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .pc_inc(pc_inc), .pc_load(pc_load), .pc_value(pc_value),
    .status_sel_en(status_sel_en), .status_sel_bit(status_sel_bit),
    .reg_a(reg_a), .reg_b(reg_b), .pc(pc), .cond_flag(cond_flag)
  );

  cycle_control i_cycle_control (
    .in_clk(in_clk), .in_rst(in_rst),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .instr(instr),
    .instr_class(instr_class), .op(op), .idx_a(idx_a), .idx_b(idx_b),
    .reg_a(reg_a), .pc(pc), .cond_flag(cond_flag),
    .alu_result(alu_result), .alu_writes(alu_writes), .flags_write(flags_write),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .pc_inc(pc_inc), .pc_load(pc_load), .pc_value(pc_value),
    .status_sel_en(status_sel_en), .status_sel_bit(status_sel_bit), .halted(halted)
  );

endmodule

// File: design/cycle_control.sv
// cycle control: fetch, immediate, execute and memory sequencer with req/ack handshake
`include "cpu16_macros.svh"

module cycle_control (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        mem_ack,
  input  logic [`CPU16_WORD_BITS-1:0] mem_rdata,
  output logic                        mem_req,
  output logic                        mem_write,
  output logic [`CPU16_ADDR_BITS-1:0] mem_addr,
  output logic [`CPU16_WORD_BITS-1:0] mem_wdata,
  output logic [`CPU16_WORD_BITS-1:0] instr,
  input  cpu16_pkg::instr_class_t     instr_class,
  input  cpu16_pkg::op_t              op,
  input  logic [`CPU16_REG_BITS-1:0]  idx_a,
  input  logic [`CPU16_REG_BITS-1:0]  idx_b,
  input  logic [`CPU16_WORD_BITS-1:0] reg_a,
  input  logic [`CPU16_ADDR_BITS-1:0] pc,
  input  logic                        cond_flag,
  input  logic [`CPU16_WORD_BITS-1:0] alu_result,
  input  logic                        alu_writes,
  input  logic                        flags_write,
  output logic                        wr_en,
  output logic [`CPU16_REG_BITS-1:0]  wr_idx,
  output logic [`CPU16_WORD_BITS-1:0] wr_data,
  output logic                        pc_inc,
  output logic                        pc_load,
  output logic [`CPU16_ADDR_BITS-1:0] pc_value,
  output logic                        status_sel_en,
  output logic [2:0]                  status_sel_bit,
  output logic                        halted
);

  cpu16_pkg::cycle_t           state;
  logic [`CPU16_WORD_BITS-1:0] imm_q;  // second instruction word

  // --------------------------------------------------
  // sequencer and memory handshake
  // --------------------------------------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state     <= cpu16_pkg::FETCH;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
      instr     <= '0;
    end else begin
      case (state)
        cpu16_pkg::FETCH, cpu16_pkg::LOAD_IMM: begin
          if (!mem_req) begin  // issue read at pc
            mem_req   <= 1'b1;
            mem_write <= 1'b0;
            mem_addr  <= pc;
          end else if (mem_ack) begin  // data valid this cycle
            mem_req <= 1'b0;
            if (state == cpu16_pkg::FETCH) begin
              instr <= mem_rdata;
              state <= cpu16_pkg::DECODE;
            end else begin
              imm_q <= mem_rdata;
              state <= cpu16_pkg::EXEC;
            end
          end
        end
        cpu16_pkg::DECODE: begin
          state <= (instr_class == cpu16_pkg::CLASS_ONE_IMM) ? cpu16_pkg::LOAD_IMM
                                                             : cpu16_pkg::EXEC;
        end
        cpu16_pkg::EXEC: begin
          case (op)
            cpu16_pkg::OP_LOAD_MEM, cpu16_pkg::OP_STORE: begin
              mem_req   <= 1'b1;
              mem_write <= op == cpu16_pkg::OP_STORE;
              mem_addr  <= imm_q;  // address from immediate
              mem_wdata <= reg_a;
              state     <= cpu16_pkg::MEM_ACCESS;
            end
            cpu16_pkg::OP_HALT, cpu16_pkg::OP_ILLEGAL: state <= cpu16_pkg::HALTED;
            default: state <= cpu16_pkg::FETCH;
          endcase
        end
        cpu16_pkg::MEM_ACCESS: begin
          if (mem_ack) begin  // hold request until ack
            mem_req   <= 1'b0;
            mem_write <= 1'b0;
            state     <= cpu16_pkg::FETCH;
          end
        end
        cpu16_pkg::HALTED: state <= cpu16_pkg::HALTED;  // only reset leaves
        default: state <= cpu16_pkg::HALTED;
      endcase
    end
  end

  assign halted = state == cpu16_pkg::HALTED;

  // write-back target and source
  assign wr_idx  = flags_write ? `CPU16_STATUS_IDX :
                   (op == cpu16_pkg::OP_MOV) ? idx_b : idx_a;
  assign wr_data = (state == cpu16_pkg::MEM_ACCESS) ? mem_rdata :
                   (op == cpu16_pkg::OP_LOAD_IMM) ? imm_q : alu_result;

  // --------------------------------------------------
  // register file strobes
  // --------------------------------------------------
  always_comb begin
    wr_en         = 1'b0;
    pc_inc        = 1'b0;
    pc_load       = 1'b0;
    status_sel_en = 1'b0;
    pc_value      = reg_a;  // absolute target
    case (state)
      cpu16_pkg::FETCH, cpu16_pkg::LOAD_IMM: pc_inc = !mem_req;  // with the request
      cpu16_pkg::EXEC: begin
        wr_en = alu_writes || flags_write || op == cpu16_pkg::OP_LOAD_IMM;
        case (op)
          cpu16_pkg::OP_JUMP_COND: pc_load = cond_flag;
          cpu16_pkg::OP_JUMP_ABS:  pc_load = 1'b1;
          cpu16_pkg::OP_JUMP_REL: begin
            pc_load  = 1'b1;
            pc_value = pc + reg_a;  // pc already past this instruction
          end
          cpu16_pkg::OP_SEL_EQ, cpu16_pkg::OP_SEL_NE, cpu16_pkg::OP_SEL_GT,
          cpu16_pkg::OP_SEL_GE, cpu16_pkg::OP_SEL_LT, cpu16_pkg::OP_SEL_LE:
            status_sel_en = 1'b1;
          default: pc_load = 1'b0;
        endcase
      end
      cpu16_pkg::MEM_ACCESS: wr_en = mem_ack && !mem_write;  // load lands at ack
      default: wr_en = 1'b0;
    endcase
  end

  // flag picked by a condition select
  always_comb begin
    case (op)
      cpu16_pkg::OP_SEL_NE: status_sel_bit = cpu16_pkg::FLAG_NE;
      cpu16_pkg::OP_SEL_GT: status_sel_bit = cpu16_pkg::FLAG_GT;
      cpu16_pkg::OP_SEL_GE: status_sel_bit = cpu16_pkg::FLAG_GE;
      cpu16_pkg::OP_SEL_LT: status_sel_bit = cpu16_pkg::FLAG_LT;
      cpu16_pkg::OP_SEL_LE: status_sel_bit = cpu16_pkg::FLAG_LE;
      default:              status_sel_bit = cpu16_pkg::FLAG_EQ;
    endcase
  end

endmodule

// File: design/instr_decoder.sv
// instruction decoder: maps an instruction word to family, operation and register fields
`include "cpu16_macros.svh"

module instr_decoder (
  input  logic [`CPU16_WORD_BITS-1:0] instr,
  output cpu16_pkg::instr_class_t     instr_class,
  output cpu16_pkg::op_t              op,
  output logic [`CPU16_REG_BITS-1:0]  idx_a,
  output logic [`CPU16_REG_BITS-1:0]  idx_b
);

  logic has_imm;  // immediate word follows

  assign has_imm = instr[`CPU16_IMM_BIT];

  // 2-register forms carry a in [7:4], 1-register forms in [3:0]
  assign idx_a = instr[`CPU16_WORD_BITS-1] ? instr[7:4] : instr[3:0];
  assign idx_b = instr[3:0];

  always_comb begin
    op = cpu16_pkg::OP_ILLEGAL;  // unmatched encodings halt
    if (instr[15]) begin  // 1_ooooooo aaaa_bbbb
      instr_class = cpu16_pkg::CLASS_TWO;
      case (instr[14:8])
        7'd0:    op = cpu16_pkg::OP_MOV;
        7'd1:    op = cpu16_pkg::OP_ADD;
        7'd2:    op = cpu16_pkg::OP_SUB;
        7'd3:    op = cpu16_pkg::OP_SHL;
        7'd4:    op = cpu16_pkg::OP_SHR;
        7'd5:    op = cpu16_pkg::OP_CMP;
        7'd6:    op = cpu16_pkg::OP_AND;
        7'd7:    op = cpu16_pkg::OP_OR;
        default: op = cpu16_pkg::OP_ILLEGAL;  // mul, div, rotate by reg
      endcase
    end else if (instr[14]) begin  // 01_i_ooooooooo_aaaa
      if (has_imm) begin
        instr_class = cpu16_pkg::CLASS_ONE_IMM;
        case (instr[12:4])
          9'd0:    op = cpu16_pkg::OP_LOAD_IMM;
          9'd1:    op = cpu16_pkg::OP_LOAD_MEM;
          9'd2:    op = cpu16_pkg::OP_STORE;
          default: op = cpu16_pkg::OP_ILLEGAL;
        endcase
      end else begin
        instr_class = cpu16_pkg::CLASS_ONE;
        case (instr[12:4])
          9'd0:    op = cpu16_pkg::OP_JUMP_COND;
          9'd1:    op = cpu16_pkg::OP_JUMP_ABS;
          9'd2:    op = cpu16_pkg::OP_JUMP_REL;
          9'd4:    op = cpu16_pkg::OP_NOT;
          9'd5:    op = cpu16_pkg::OP_LNOT;
          9'd8:    op = cpu16_pkg::OP_SHL1;
          9'd9:    op = cpu16_pkg::OP_SHR1;
          9'd10:   op = cpu16_pkg::OP_ROL1;
          9'd11:   op = cpu16_pkg::OP_ROR1;
          default: op = cpu16_pkg::OP_ILLEGAL;  // call, push, pop gone
        endcase
      end
    end else begin  // 00_i_ooooo oooo_oooo
      instr_class = cpu16_pkg::CLASS_ZERO;
      if (!has_imm) begin  // immediate 0-register forms stay illegal
        case (instr[12:0])
          13'd0:   op = cpu16_pkg::OP_HALT;
          13'd1:   op = cpu16_pkg::OP_NOP;
          13'd4:   op = cpu16_pkg::OP_SEL_EQ;
          13'd5:   op = cpu16_pkg::OP_SEL_NE;
          13'd6:   op = cpu16_pkg::OP_SEL_GT;
          13'd7:   op = cpu16_pkg::OP_SEL_GE;
          13'd8:   op = cpu16_pkg::OP_SEL_LT;
          13'd9:   op = cpu16_pkg::OP_SEL_LE;
          default: op = cpu16_pkg::OP_ILLEGAL;  // returns, irq number
        endcase
      end
    end
  end

endmodule

// File: design/register_file.sv
// register file: sixteen words with pc at register 12 and condition select on status
`include "cpu16_macros.svh"

module register_file (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic [`CPU16_REG_BITS-1:0]  idx_a,
  input  logic [`CPU16_REG_BITS-1:0]  idx_b,
  input  logic                        wr_en,
  input  logic [`CPU16_REG_BITS-1:0]  wr_idx,
  input  logic [`CPU16_WORD_BITS-1:0] wr_data,
  input  logic                        pc_inc,
  input  logic                        pc_load,
  input  logic [`CPU16_ADDR_BITS-1:0] pc_value,
  input  logic                        status_sel_en,
  input  logic [2:0]                  status_sel_bit,
  output logic [`CPU16_WORD_BITS-1:0] reg_a,
  output logic [`CPU16_WORD_BITS-1:0] reg_b,
  output logic [`CPU16_ADDR_BITS-1:0] pc,
  output logic                        cond_flag
);

  logic [`CPU16_WORD_BITS-1:0] regs [`CPU16_NUM_REGS];

  // read ports
  assign reg_a     = regs[idx_a];
  assign reg_b     = regs[idx_b];
  assign pc        = regs[`CPU16_IP_IDX];
  assign cond_flag = regs[`CPU16_STATUS_IDX][cpu16_pkg::FLAG_EQ];  // shares the eq slot

  // one update source per cycle, sequencer keeps them exclusive
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < `CPU16_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      regs[`CPU16_IP_IDX] <= `CPU16_ENTRY_ADDR;
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end else if (pc_inc) begin
      regs[`CPU16_IP_IDX] <= regs[`CPU16_IP_IDX] + 1'b1;  // past fetched word
    end else if (pc_load) begin
      regs[`CPU16_IP_IDX] <= pc_value;  // jump target
    end else if (status_sel_en) begin
      regs[`CPU16_STATUS_IDX][cpu16_pkg::FLAG_EQ] <=
        regs[`CPU16_STATUS_IDX][status_sel_bit];  // chosen flag -> bit 0
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cpu16 testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu16_tb \
  -f cpu16.f -o sim_cpu16 || { echo "build failed"; exit 1; }

./obj_dir/sim_cpu16 > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: verification/cpu16_asserts.sv
// cpu16 handshake checks: request hold, release after ack, sticky halt, exclusive updates
`include "cpu16_macros.svh"

module cpu16_asserts (
  input logic                        in_clk,
  input logic                        in_rst,
  input logic                        mem_req,
  input logic                        mem_ack,
  input logic                        mem_write,
  input logic [`CPU16_ADDR_BITS-1:0] mem_addr,
  input logic                        halted,
  input logic                        wr_en,
  input logic                        pc_inc,
  input logic                        pc_load
);
  timeunit 1ns;
  timeprecision 100ps;

  // request held with stable address until ack
  req_hold: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_write))
    else $error("mem_req dropped or address changed before ack");

  // request released after ack
  req_release: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_req && mem_ack |=> !mem_req)
    else $error("mem_req still high after ack");

  // only reset leaves halt
  halt_sticky: assert property (@(posedge in_clk)
    halted && !in_rst |=> halted)
    else $error("halted fell without reset");

  update_onehot: assert property (@(posedge in_clk) disable iff (in_rst)
    $onehot0({wr_en, pc_inc, pc_load}))
    else $error("more than one register update strobe active");

endmodule

bind cycle_control cpu16_asserts i_cpu16_asserts (.*);

// File: verification/cpu16_tb.sv
// cpu16 testbench running short programs through a memory model and checking stores against a reference
`include "cpu16_macros.svh"

module cpu16_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 6;
  localparam int HALT_LIMIT = 1000;  // cycles per program

  logic                        in_clk, in_rst, mem_ack, mem_req, mem_write, halted;
  logic [`CPU16_WORD_BITS-1:0] mem_rdata, mem_wdata, instr;
  logic [`CPU16_ADDR_BITS-1:0] mem_addr, pc;
  logic [`CPU16_WORD_BITS-1:0] mem [65536];      // DUT side memory
  logic [`CPU16_WORD_BITS-1:0] ref_mem [65536];  // reference copy
  logic [`CPU16_WORD_BITS-1:0] prog [$];
  logic [`CPU16_ADDR_BITS-1:0] exp_addr [$];
  logic [`CPU16_WORD_BITS-1:0] exp_data [$];
  logic [`CPU16_WORD_BITS-1:0] exp_instr;        // last word the reference ran
  logic [31:0]                 lfsr_state;
  int                          errors, tests_failed, test_no;

  cpu16_top i_cpu16_top (
    .in_clk(in_clk), .in_rst(in_rst), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .instr(instr), .pc(pc), .halted(halted)
  );

  initial begin
    in_clk = 1'b0;
    forever #50 in_clk = ~in_clk;  // 100 ns period
  end

  // --------------------------------------------------
  // random source and encoders
  // --------------------------------------------------
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[14:0], lfsr_step()};  // one step per bit
    return v;
  endfunction

  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return a ^ {a[7:0], a[15:8]} ^ 16'h3c5a;  // differs per address
  endfunction

  task automatic append_word(input logic [15:0] w);
    prog.push_back(w);
  endtask

  task automatic two_reg_op(input logic [6:0] o, input logic [3:0] a, input logic [3:0] b);
    append_word({1'b1, o, a, b});
  endtask

  task automatic one_reg_op(input logic [8:0] o, input logic [3:0] a);
    append_word({3'b010, o, a});
  endtask

  task automatic imm_op(input logic [8:0] o, input logic [3:0] a, input logic [15:0] imm);
    append_word({3'b011, o, a});  // 0 load imm, 1 load mem, 2 store
    append_word(imm);
  endtask

  task automatic control_op(input logic [12:0] o);
    append_word({3'b000, o});  // 0 halt, 1 nop, 4..9 selects
  endtask

  // --------------------------------------------------
  // reference interpreter returning pc at halt
  // --------------------------------------------------
  function automatic logic [15:0] reference_run();
    logic [15:0] r [16];
    logic [15:0] rpc, w, imm;
    logic [3:0]  a, b, sel;
    for (int i = 0; i < 16; i++) r[i] = '0;
    rpc = `CPU16_ENTRY_ADDR;
    for (int step = 0; step < 4000; step++) begin
      w         = ref_mem[rpc];
      exp_instr = w;
      rpc       = rpc + 16'd1;
      a         = w[15] ? w[7:4] : w[3:0];
      b         = w[3:0];
      sel       = w[3:0] - 4'd4;
      if (w[15]) begin
        case (w[14:8])
          7'd0: r[b] = r[a];  // transfer into b
          7'd1: r[a] = r[a] + r[b];
          7'd2: r[a] = r[a] - r[b];
          7'd3: r[a] = r[a] << r[b];
          7'd4: r[a] = r[a] >> r[b];
          7'd5: r[15] = {r[15][15:6], r[a] <= r[b], r[a] < r[b], r[a] >= r[b],
                         r[a] > r[b], r[a] != r[b], r[a] == r[b]};
          7'd6: r[a] = r[a] & r[b];
          7'd7: r[a] = r[a] | r[b];
          default: return rpc;
        endcase
      end else if (w[14] && w[13]) begin
        imm = ref_mem[rpc];
        rpc = rpc + 16'd1;  // immediate fetched before execute
        case (w[12:4])
          9'd0: r[a] = imm;
          9'd1: r[a] = ref_mem[imm];
          9'd2: begin
            ref_mem[imm] = r[a];
            exp_addr.push_back(imm);
            exp_data.push_back(r[a]);
          end
          default: return rpc;
        endcase
      end else if (w[14]) begin
        case (w[12:4])
          9'd0:  if (r[15][0]) rpc = r[a];
          9'd1:  rpc = r[a];
          9'd2:  rpc = rpc + r[a];  // relative to next instruction
          9'd4:  r[a] = ~r[a];
          9'd5:  r[a] = (r[a] == 16'd0) ? 16'd1 : 16'd0;
          9'd8:  r[a] = {r[a][14:0], 1'b0};
          9'd9:  r[a] = {1'b0, r[a][15:1]};
          9'd10: r[a] = {r[a][14:0], r[a][15]};
          9'd11: r[a] = {r[a][0], r[a][15:1]};
          default: return rpc;
        endcase
      end else if (!w[13] && w[12:0] == 13'd1) begin
        r[0] = r[0];  // nop
      end else if (!w[13] && w[12:0] >= 13'd4 && w[12:0] <= 13'd9) begin
        r[15][0] = r[15][sel];
      end else begin
        return rpc;
      end
    end
    return rpc;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic compare_word(input string name, input logic [`CPU16_WORD_BITS-1:0] got,
                              input logic [`CPU16_WORD_BITS-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_addr(input string name, input logic [`CPU16_ADDR_BITS-1:0] got,
                              input logic [`CPU16_ADDR_BITS-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // memory model acking 1 to 4 cycles after a request
  initial begin
    logic [2:0] delay;
    forever begin
      @(posedge in_clk);
      if (!in_rst && mem_req) begin
        delay = 3'd1 + 3'(rand_bits(2));
        repeat (delay - 1) @(posedge in_clk);
        #10;
        mem_ack   = 1'b1;
        mem_rdata = mem[mem_addr];
        if (mem_write) mem[mem_addr] = mem_wdata;
        @(posedge in_clk);
        #10 mem_ack = 1'b0;
      end
    end
  end

  // store checker sampled mid cycle
  always @(negedge in_clk) begin
    if (!in_rst && mem_req && mem_write && mem_ack) begin
      if (exp_addr.size() == 0) begin
        $display("error at %0t: store to %h was not expected", $time, mem_addr);
        errors++;
      end else begin
        compare_addr("mem_addr", mem_addr, exp_addr.pop_front());
        compare_word("mem_wdata", mem_wdata, exp_data.pop_front());
      end
    end
  end

  task automatic run_test(input string name);
    int          start_err, cycles;
    logic [15:0] exp_pc;
    start_err = errors;
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = fill_word(16'(i));
      ref_mem[i] = fill_word(16'(i));
    end
    foreach (prog[i]) begin
      mem[i]     = prog[i];
      ref_mem[i] = prog[i];
    end
    exp_addr.delete();
    exp_data.delete();
    exp_pc = reference_run();
    @(posedge in_clk);
    #10 in_rst = 1'b1;
    repeat (4) @(posedge in_clk);
    #10 in_rst = 1'b0;
    if (halted || mem_req) begin
      $display("error at %0t: halted or mem_req high after reset", $time);
      errors++;
    end
    cycles = 0;
    while (!halted && cycles < HALT_LIMIT) begin
      @(negedge in_clk);
      cycles++;
    end
    if (!halted) begin
      $display("error at %0t: cpu did not halt in time", $time);
      errors++;
    end
    repeat (8) begin
      @(negedge in_clk);
      if (mem_req) begin
        $display("error at %0t: memory request after halt", $time);
        errors++;
      end
    end
    compare_addr("pc", pc, exp_pc);
    compare_word("instr", instr, exp_instr);
    if (exp_addr.size() != 0) begin
      $display("error at %0t: %0d expected stores never seen", $time, exp_addr.size());
      errors++;
    end
    test_no++;
    if (errors == start_err) $display("test %0d %s: ok", test_no, name);
    else begin
      tests_failed++;
      $display("test %0d %s: FAILED", test_no, name);
    end
    prog.delete();
  endtask

  // --------------------------------------------------
  // programs
  // --------------------------------------------------
  task automatic alu_program();
    int ops [6] = '{1, 2, 6, 7, 3, 4};  // add sub and or shl shr
    imm_op(0, 1, rand_bits(16));
    imm_op(0, 2, rand_bits(16));
    imm_op(0, 4, rand_bits(4));  // shift amount
    for (int k = 0; k < 6; k++) begin
      two_reg_op(0, 1, 3);
      two_reg_op(7'(ops[k]), 3, (ops[k] >= 3 && ops[k] <= 4) ? 4'd4 : 4'd2);
      imm_op(2, 3, 16'h4000 + 16'(k));
    end
    two_reg_op(0, 1, 5);
    imm_op(2, 5, 16'h4010);
    control_op(0);
  endtask

  task automatic unary_program();
    int ops [6] = '{4, 5, 8, 9, 10, 11};  // not lnot shl1 shr1 rol1 ror1
    imm_op(0, 1, rand_bits(16));
    for (int k = 0; k < 6; k++) begin
      two_reg_op(0, 1, 3);
      one_reg_op(9'(ops[k]), 3);
      imm_op(2, 3, 16'h4100 + 16'(k));
    end
    imm_op(0, 6, 16'h0000);
    one_reg_op(5, 6);  // lnot of zero
    imm_op(2, 6, 16'h4110);
    control_op(0);
  endtask

  task automatic compare_program();
    logic [15:0] x;
    x = rand_bits(16);
    imm_op(0, 1, x);
    for (int k = 0; k < 6; k++) begin
      imm_op(0, 2, k[0] ? rand_bits(16) : x);  // even rounds compare equal
      two_reg_op(5, 1, 2);
      control_op(13'(4 + k));
      imm_op(2, 15, 16'h4200 + 16'(k));
    end
    control_op(0);
  endtask

  task automatic jump_program();
    int p;
    imm_op(0, 2, 16'h1111);
    imm_op(0, 4, 16'h2222);
    imm_op(0, 1, 0);  // absolute target patched below
    p = prog.size() - 1;
    one_reg_op(1, 1);
    imm_op(2, 2, 16'h4300);
    prog[p] = 16'(prog.size());
    imm_op(0, 3, 2);  // relative hop over one store
    one_reg_op(2, 3);
    imm_op(2, 2, 16'h4301);
    imm_op(2, 4, 16'h4302);
    imm_op(0, 5, 7);
    imm_op(0, 6, 7);
    two_reg_op(5, 5, 6);  // equal so taken
    imm_op(0, 1, 0);
    p = prog.size() - 1;
    one_reg_op(0, 1);
    imm_op(2, 2, 16'h4303);
    prog[p] = 16'(prog.size());
    imm_op(2, 4, 16'h4304);
    imm_op(0, 6, 8);
    two_reg_op(5, 5, 6);  // not equal so falls through
    imm_op(0, 1, 0);
    p = prog.size() - 1;
    one_reg_op(0, 1);
    imm_op(2, 2, 16'h4305);
    prog[p] = 16'(prog.size());
    imm_op(2, 4, 16'h4306);
    control_op(0);
  endtask

  initial begin
    lfsr_state   = 32'h3ad6dc33;
    in_rst       = 1'b1;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    errors       = 0;
    tests_failed = 0;
    test_no      = 0;
    alu_program();
    run_test("alu two-register");
    unary_program();
    run_test("one-register");
    compare_program();
    run_test("compare and select");
    jump_program();
    run_test("jumps");
    imm_op(0, 1, rand_bits(16));  // store then load back and store again
    imm_op(2, 1, 16'h5000);
    imm_op(1, 7, 16'h5000);
    imm_op(2, 7, 16'h5001);
    control_op(0);
    run_test("memory load and store");
    imm_op(0, 1, rand_bits(16));
    imm_op(2, 1, 16'h4400);
    append_word(16'h8800);  // reserved two-register opcode
    imm_op(2, 1, 16'h4401);
    control_op(0);
    run_test("illegal encoding");
    $display("tests run %0d, failed %0d, errors %0d", test_no, tests_failed, errors);
    if (errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * 400 * 100);
    $display("error at %0t: watchdog expired", $time);
    $display("tests failed");
    $finish;
  end

endmodule
